// ==== design/matmul_cfg.svh ====
`ifndef MATMUL_CFG_SVH
`define MATMUL_CFG_SVH

//////////////////////////////////////////////////
// Data and address widths
//////////////////////////////////////////////////
`define MM_DWIDTH       8
`define MM_AWIDTH       11
`define MM_STRIDE_WIDTH 8

// The array is fixed at 4x4
`define MM_SIZE         4
`define MM_LOG2_SIZE    2

//////////////////////////////////////////////////
// Latencies and cycle counting
//////////////////////////////////////////////////
`define MM_MAC_STAGES   3
`define MM_MEM_LATENCY  1
`define MM_CNT_WIDTH    6

// Fetch length, skew depth, array traversal, MAC pipe and memory latency
`define MM_RESULT_CNT   (`MM_SIZE + (`MM_SIZE - 1) + (`MM_SIZE - 1) + `MM_MAC_STAGES + `MM_MEM_LATENCY)

`endif

// ==== design/matmul_pkg.sv ====
`include "matmul_cfg.svh"

package matmul_pkg;

  //////////////////////////////////////////////////
  // Datapath types
  //////////////////////////////////////////////////

  // One signed fixed-point matrix element
  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // Full width product of two elements
  typedef logic [2*`MM_DWIDTH-1:0] prod_t;

  // One memory word, element i in slice i
  typedef logic [`MM_SIZE*`MM_DWIDTH-1:0] vec_t;

  //////////////////////////////////////////////////
  // Control types
  //////////////////////////////////////////////////
  typedef logic [`MM_AWIDTH-1:0] addr_t;
  typedef logic [`MM_STRIDE_WIDTH-1:0] stride_t;

  // One bit per row or column
  typedef logic [`MM_SIZE-1:0] mask_t;

  typedef logic [`MM_CNT_WIDTH-1:0] cnt_t;

endpackage

// ==== design/matmul_ctrl.sv ====
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module matmul_ctrl (
  input  logic             clk,
  input  logic             reset,
  input  logic             i_start,
  output logic             o_clear,
  output matmul_pkg::cnt_t o_cnt,
  output logic             o_result_latch,
  output logic             o_done
);
  import matmul_pkg::*;

  // Done lands one cycle after the last of the four result beats
  localparam cnt_t done_cnt = cnt_t'(`MM_RESULT_CNT + `MM_SIZE + 1);

  cnt_t cnt_q;

  // Everything downstream is held empty while start is low
  assign o_clear = reset || !i_start;

  //////////////////////////////////////////////////
  // Cycle counter
  //////////////////////////////////////////////////
  // Stops at the done count so a held start never retriggers the product
  always_ff @(posedge clk) begin
    if (o_clear) begin
      cnt_q <= '0;
    end else if (cnt_q != done_cnt) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign o_cnt = cnt_q;

  // All accumulators hold their final sums at this count
  assign o_result_latch = (cnt_q == cnt_t'(`MM_RESULT_CNT));

  always_ff @(posedge clk) begin
    if (o_clear) begin
      o_done <= 1'b0;
    end else begin
      o_done <= (cnt_q == done_cnt - 1'b1);
    end
  end

  a_done_single: assert property (@(posedge clk) disable iff (reset)
    o_done |=> !o_done)
    else $error("done held for more than one cycle");

  a_done_at_count: assert property (@(posedge clk) disable iff (reset)
    $rose(o_done) |-> !$past(o_clear) && o_cnt == done_cnt)
    else $error("done raised away from the done count");

endmodule

// ==== design/operand_feeder.sv ====
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module operand_feeder (
  input  logic                clk,
  input  logic                i_clear,
  input  matmul_pkg::cnt_t    i_cnt,
  input  matmul_pkg::addr_t   i_base,
  input  matmul_pkg::stride_t i_stride,
  input  matmul_pkg::vec_t    i_data,
  input  matmul_pkg::mask_t   i_lane_mask,
  input  matmul_pkg::mask_t   i_inner_mask,
  output matmul_pkg::addr_t   o_addr,
  output matmul_pkg::vec_t    o_lanes
);
  import matmul_pkg::*;

  logic                     req_q;
  logic [`MM_LOG2_SIZE-1:0] req_idx_q;
  logic                     vld_pipe [`MM_MEM_LATENCY];
  logic [`MM_LOG2_SIZE-1:0] idx_pipe [`MM_MEM_LATENCY];
  logic                     beat_ok;
  elem_t                    lane_in [`MM_SIZE];

  //////////////////////////////////////////////////
  // Strided address window
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_addr <= '0;
    end else if (i_cnt == '0) begin
      o_addr <= i_base;
    end else if (i_cnt < `MM_SIZE) begin
      o_addr <= o_addr + addr_t'(i_stride);
    end
  end

  // Marks the cycles that carry a read address and which beat it is
  always_ff @(posedge clk) begin
    if (i_clear) begin
      req_q <= 1'b0;
    end else begin
      req_q <= (i_cnt < `MM_SIZE);
    end
  end

  always_ff @(posedge clk) begin
    req_idx_q <= i_cnt[`MM_LOG2_SIZE-1:0];
  end

  //////////////////////////////////////////////////
  // Valid tracking across the memory latency
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_clear) begin
      for (int s = 0; s < `MM_MEM_LATENCY; s++) begin
        vld_pipe[s] <= 1'b0;
      end
    end else begin
      vld_pipe[0] <= req_q;
      for (int s = 1; s < `MM_MEM_LATENCY; s++) begin
        vld_pipe[s] <= vld_pipe[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    idx_pipe[0] <= req_idx_q;
    for (int s = 1; s < `MM_MEM_LATENCY; s++) begin
      idx_pipe[s] <= idx_pipe[s-1];
    end
  end

  // An inner term dropped by the mask contributes a zero beat
  assign beat_ok = vld_pipe[`MM_MEM_LATENCY-1] && i_inner_mask[idx_pipe[`MM_MEM_LATENCY-1]];

  always_comb begin
    for (int i = 0; i < `MM_SIZE; i++) begin
      lane_in[i] = (beat_ok && i_lane_mask[i]) ? i_data[i*`MM_DWIDTH +: `MM_DWIDTH] : '0;
    end
  end

  //////////////////////////////////////////////////
  // Lane i waits i cycles to form the systolic skew
  //////////////////////////////////////////////////
  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign o_lanes[i*`MM_DWIDTH +: `MM_DWIDTH] = lane_in[i];
    end else begin : g_delay
      elem_t dly_q [i];

      always_ff @(posedge clk) begin
        if (i_clear) begin
          for (int s = 0; s < i; s++) begin
            dly_q[s] <= '0;
          end
        end else begin
          dly_q[0] <= lane_in[i];
          for (int s = 1; s < i; s++) begin
            dly_q[s] <= dly_q[s-1];
          end
        end
      end

      assign o_lanes[i*`MM_DWIDTH +: `MM_DWIDTH] = dly_q[i-1];
    end
  end

  a_addr_window: assert property (@(posedge clk) disable iff (i_clear)
    !$stable(o_addr) && !$past(i_clear) |-> $past(i_cnt) < `MM_SIZE)
    else $error("operand address moved outside the fetch window");

endmodule

// ==== design/pe_mac.sv ====
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module pe_mac (
  input  logic              clk,
  input  logic              i_clear,
  input  matmul_pkg::elem_t i_a,
  input  matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t o_a,
  output matmul_pkg::elem_t o_b,
  output matmul_pkg::elem_t o_c
);
  import matmul_pkg::*;

  elem_t a_q;
  elem_t b_q;
  prod_t prod_q;
  elem_t prod_sat;
  elem_t acc_q;

  // The operand stage is also the hop to the right and lower neighbours
  always_ff @(posedge clk) begin
    if (i_clear) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= i_a;
      b_q <= i_b;
    end
  end

  assign o_a = a_q;
  assign o_b = b_q;

  always_ff @(posedge clk) begin
    if (i_clear) begin
      prod_q <= '0;
    end else begin
      prod_q <= $signed(a_q) * $signed(b_q);
    end
  end

  //////////////////////////////////////////////////
  // Saturate the product to the element range
  //////////////////////////////////////////////////
  // The top nine bits must all match the sign, otherwise the value is out of range
  always_comb begin
    if (!prod_q[2*`MM_DWIDTH-1] && |prod_q[2*`MM_DWIDTH-2:`MM_DWIDTH-1]) begin
      prod_sat = {1'b0, {(`MM_DWIDTH-1){1'b1}}};
    end else if (prod_q[2*`MM_DWIDTH-1] && !(&prod_q[2*`MM_DWIDTH-2:`MM_DWIDTH-1])) begin
      prod_sat = {1'b1, {(`MM_DWIDTH-1){1'b0}}};
    end else begin
      prod_sat = prod_q[`MM_DWIDTH-1:0];
    end
  end

  // The running sum wraps modulo 256
  always_ff @(posedge clk) begin
    if (i_clear) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_q + prod_sat;
    end
  end

  assign o_c = acc_q;

endmodule

// ==== design/systolic_array.sv ====
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module systolic_array (
  input  logic                                       clk,
  input  logic                                       i_clear,
  input  matmul_pkg::vec_t                           i_a_lanes,
  input  matmul_pkg::vec_t                           i_b_lanes,
  output matmul_pkg::elem_t [`MM_SIZE*`MM_SIZE-1:0]  o_c_flat
);
  import matmul_pkg::*;

  // A moves right along a row, B moves down a column
  elem_t a_fwd [`MM_SIZE][`MM_SIZE+1];
  elem_t b_fwd [`MM_SIZE+1][`MM_SIZE];

  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_edge
    assign a_fwd[i][0] = i_a_lanes[i*`MM_DWIDTH +: `MM_DWIDTH];
    assign b_fwd[0][i] = i_b_lanes[i*`MM_DWIDTH +: `MM_DWIDTH];
  end

  //////////////////////////////////////////////////
  // Processing element grid
  //////////////////////////////////////////////////
  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_row
    for (genvar j = 0; j < `MM_SIZE; j++) begin : g_col
      pe_mac i_pe_mac (
        .clk     (clk),
        .i_clear (i_clear),
        .i_a     (a_fwd[i][j]),
        .i_b     (b_fwd[i][j]),
        .o_a     (a_fwd[i][j+1]),
        .o_b     (b_fwd[i+1][j]),
        .o_c     (o_c_flat[i*`MM_SIZE+j])
      );
    end
  end

endmodule

// ==== design/result_shifter.sv ====
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module result_shifter (
  input  logic                                      clk,
  input  logic                                      i_clear,
  input  logic                                      i_result_latch,
  input  matmul_pkg::elem_t [`MM_SIZE*`MM_SIZE-1:0] i_c_flat,
  input  matmul_pkg::addr_t                         i_c_base,
  input  matmul_pkg::stride_t                       i_c_stride,
  output matmul_pkg::vec_t                          o_c_data,
  output matmul_pkg::addr_t                         o_c_addr,
  output logic                                      o_c_data_available
);
  import matmul_pkg::*;

  elem_t [`MM_SIZE*`MM_SIZE-1:0] snap_q;
  logic [`MM_LOG2_SIZE-1:0]      col_q;

  // Gathers column col of a row-major matrix, row i into slice i
  function automatic vec_t pick_col(input elem_t [`MM_SIZE*`MM_SIZE-1:0] c,
                                    input logic [`MM_LOG2_SIZE-1:0] col);
    vec_t v;
    for (int i = 0; i < `MM_SIZE; i++) begin
      v[i*`MM_DWIDTH +: `MM_DWIDTH] = c[i*`MM_SIZE + col];
    end
    return v;
  endfunction

  always_ff @(posedge clk) begin
    if (i_result_latch) begin
      snap_q <= i_c_flat;
    end
  end

  //////////////////////////////////////////////////
  // Column beats
  //////////////////////////////////////////////////
  // Column 0 goes out straight from the array, the rest from the snapshot
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_c_data_available <= 1'b0;
      o_c_data           <= '0;
      o_c_addr           <= '0;
      col_q              <= '0;
    end else if (i_result_latch) begin
      o_c_data_available <= 1'b1;
      o_c_data           <= pick_col(i_c_flat, '0);
      o_c_addr           <= i_c_base;
      col_q              <= 1'b1;
    end else if (o_c_data_available && col_q != '0) begin
      o_c_data <= pick_col(snap_q, col_q);
      o_c_addr <= o_c_addr + addr_t'(i_c_stride);
      col_q    <= col_q + 1'b1;
    end else begin
      // Counter wrapped to zero after the last column
      o_c_data_available <= 1'b0;
      o_c_data           <= '0;
    end
  end

  a_avail_after_latch: assert property (@(posedge clk)
    $rose(o_c_data_available) |-> $past(i_result_latch) && !$past(i_clear))
    else $error("result beats started without a latch or during clear");

endmodule

// ==== design/matmul_top.sv ====
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module matmul_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_start,
  input  matmul_pkg::addr_t   i_addr_a,
  input  matmul_pkg::addr_t   i_addr_b,
  input  matmul_pkg::addr_t   i_addr_c,
  input  matmul_pkg::stride_t i_stride_a,
  input  matmul_pkg::stride_t i_stride_b,
  input  matmul_pkg::stride_t i_stride_c,
  input  matmul_pkg::vec_t    i_a_data,
  input  matmul_pkg::vec_t    i_b_data,
  input  matmul_pkg::mask_t   i_mask_a_rows,
  input  matmul_pkg::mask_t   i_mask_inner,
  input  matmul_pkg::mask_t   i_mask_b_cols,
  output matmul_pkg::addr_t   o_a_addr,
  output matmul_pkg::addr_t   o_b_addr,
  output matmul_pkg::addr_t   o_c_addr,
  output matmul_pkg::vec_t    o_c_data,
  output logic                o_c_data_available,
  output logic                o_done
);
  import matmul_pkg::*;

  logic                          clear;
  logic                          result_latch;
  cnt_t                          cnt;
  vec_t                          a_lanes;
  vec_t                          b_lanes;
  elem_t [`MM_SIZE*`MM_SIZE-1:0] c_flat;

  matmul_ctrl i_matmul_ctrl (
    .clk            (clk),
    .reset          (reset),
    .i_start        (i_start),
    .o_clear        (clear),
    .o_cnt          (cnt),
    .o_result_latch (result_latch),
    .o_done         (o_done)
  );

  // A is fetched one column per word and masked by row
  operand_feeder i_feeder_a (
    .clk          (clk),
    .i_clear      (clear),
    .i_cnt        (cnt),
    .i_base       (i_addr_a),
    .i_stride     (i_stride_a),
    .i_data       (i_a_data),
    .i_lane_mask  (i_mask_a_rows),
    .i_inner_mask (i_mask_inner),
    .o_addr       (o_a_addr),
    .o_lanes      (a_lanes)
  );

  // B is fetched one row per word and masked by column
  operand_feeder i_feeder_b (
    .clk          (clk),
    .i_clear      (clear),
    .i_cnt        (cnt),
    .i_base       (i_addr_b),
    .i_stride     (i_stride_b),
    .i_data       (i_b_data),
    .i_lane_mask  (i_mask_b_cols),
    .i_inner_mask (i_mask_inner),
    .o_addr       (o_b_addr),
    .o_lanes      (b_lanes)
  );

  systolic_array i_systolic_array (
    .clk       (clk),
    .i_clear   (clear),
    .i_a_lanes (a_lanes),
    .i_b_lanes (b_lanes),
    .o_c_flat  (c_flat)
  );

  result_shifter i_result_shifter (
    .clk                (clk),
    .i_clear            (clear),
    .i_result_latch     (result_latch),
    .i_c_flat           (c_flat),
    .i_c_base           (i_addr_c),
    .i_c_stride         (i_stride_c),
    .o_c_data           (o_c_data),
    .o_c_addr           (o_c_addr),
    .o_c_data_available (o_c_data_available)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset
);

  // 20 ns clock period
  localparam int half_period = 10;

  initial begin
    o_clk = 1'b0;
    forever begin
      #half_period;
      o_clk = ~o_clk;
    end
  end

  // Reset covers the first two rising edges
  initial begin
    o_reset = 1'b1;
    repeat (2) @(posedge o_clk);
    #1;
    o_reset = 1'b0;
  end

endmodule

// ==== sim/tb_matmul.sv ====
`timescale 1ns/100ps
`include "matmul_cfg.svh"

module tb_matmul;
  import matmul_pkg::*;

  localparam int dw          = `MM_DWIDTH;
  localparam int n           = `MM_SIZE;
  localparam int max_cases   = 32;
  localparam int case_cycles = 40;
  localparam int mem_words   = 1 << `MM_AWIDTH;
  localparam int n_fields    = 21;

  logic    clk;
  logic    reset;
  logic    start;
  addr_t   addr_a;
  addr_t   addr_b;
  addr_t   addr_c;
  stride_t stride_a;
  stride_t stride_b;
  stride_t stride_c;
  vec_t    a_data;
  vec_t    b_data;
  mask_t   mask_a_rows;
  mask_t   mask_inner;
  mask_t   mask_b_cols;
  addr_t   a_addr;
  addr_t   b_addr;
  addr_t   c_addr;
  vec_t    c_data;
  logic    c_data_available;
  logic    done;

  // Fields per case: bases A B C, strides A B C, masks rows inner cols,
  // four A column words, four B row words, four expected C column words
  string       case_name  [max_cases];
  int          case_mode  [max_cases];
  logic [31:0] case_field [max_cases][n_fields];
  int          n_cases;
  logic        cases_loaded;

  vec_t        mem [mem_words];
  vec_t        exp_col [n];
  addr_t       a_rd_q = '0;
  addr_t       b_rd_q = '0;
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;

  tb_clock_gen i_tb_clock_gen (
    .o_clk   (clk),
    .o_reset (reset)
  );

  matmul_top i_matmul_top (
    .clk                (clk),
    .reset              (reset),
    .i_start            (start),
    .i_addr_a           (addr_a),
    .i_addr_b           (addr_b),
    .i_addr_c           (addr_c),
    .i_stride_a         (stride_a),
    .i_stride_b         (stride_b),
    .i_stride_c         (stride_c),
    .i_a_data           (a_data),
    .i_b_data           (b_data),
    .i_mask_a_rows      (mask_a_rows),
    .i_mask_inner       (mask_inner),
    .i_mask_b_cols      (mask_b_cols),
    .o_a_addr           (a_addr),
    .o_b_addr           (b_addr),
    .o_c_addr           (c_addr),
    .o_c_data           (c_data),
    .o_c_data_available (c_data_available),
    .o_done             (done)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic compare(input string name, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch in %s, %s: expected %h, actual %h", name, what, expected, actual);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int nbits, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < nbits; b++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic addr_t word_addr(input addr_t base, input stride_t stride, input int k);
    return base + addr_t'(k) * addr_t'(stride);
  endfunction

  // Unused words hold a copy of their own address
  function automatic vec_t background_word(input addr_t a);
    return {5'h15, a, 5'h0a, a};
  endfunction

  function automatic elem_t sat_product(input elem_t a, input elem_t b);
    int p;
    p = int'($signed(a)) * int'($signed(b));
    if (p > 127) begin
      return 8'h7f;
    end
    if (p < -128) begin
      return 8'h80;
    end
    return elem_t'(p);
  endfunction

  task automatic load_cases();
    int    fd;
    int    got;
    string tok;
    string rest;
    fd = $fopen("sim/matmul_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file sim/matmul_cases.txt");
      errors++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.getc(0) == "#") begin
        got = $fgets(rest, fd);
      end else if (n_cases < max_cases) begin
        case_name[n_cases] = tok;
        got = $fscanf(fd, "%d", case_mode[n_cases]);
        for (int f = 0; f < n_fields; f++) begin
          got += $fscanf(fd, "%h", case_field[n_cases][f]);
        end
        if (got != n_fields + 1) begin
          $display("Case %s in the case file is incomplete", tok);
          errors++;
        end else begin
          n_cases++;
        end
      end
    end
    $fclose(fd);
    if (n_cases == 0) begin
      $display("The case file holds no cases");
      errors++;
    end
  endtask

  task automatic place_operands(input int c);
    for (int a = 0; a < mem_words; a++) begin
      mem[a] = background_word(addr_t'(a));
    end
    for (int k = 0; k < n; k++) begin
      mem[word_addr(addr_t'(case_field[c][0]), stride_t'(case_field[c][3]), k)] =
        case_field[c][9+k];
      mem[word_addr(addr_t'(case_field[c][1]), stride_t'(case_field[c][4]), k)] =
        case_field[c][13+k];
    end
  endtask

  // C(i,j) sums the saturated products over the enabled inner terms
  task automatic build_expected(input int c);
    vec_t  a_word;
    vec_t  b_word;
    elem_t sum;
    for (int j = 0; j < n; j++) begin
      for (int i = 0; i < n; i++) begin
        sum = '0;
        for (int k = 0; k < n; k++) begin
          a_word = mem[word_addr(addr_t'(case_field[c][0]), stride_t'(case_field[c][3]), k)];
          b_word = mem[word_addr(addr_t'(case_field[c][1]), stride_t'(case_field[c][4]), k)];
          if (case_field[c][7][k]) begin
            sum = sum + sat_product(a_word[i*dw +: dw], b_word[j*dw +: dw]);
          end
        end
        if (!case_field[c][6][i] || !case_field[c][8][j]) begin
          sum = '0;
        end
        exp_col[j][i*dw +: dw] = sum;
      end
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // One product from start to done
  //////////////////////////////////////////////////
  task automatic run_case(input int c);
    string name;
    int    beats;
    int    cycles;
    logic  avail_prev;
    logic  seen_done;
    name = case_name[c];
    if (case_mode[c] == 1) begin
      for (int k = 0; k < 2*n; k++) begin
        random_bits(32, case_field[c][9+k]);
      end
    end
    place_operands(c);
    build_expected(c);
    if (case_mode[c] == 0) begin
      for (int j = 0; j < n; j++) begin
        exp_col[j] = case_field[c][17+j];
      end
    end

    @(posedge clk);
    #1;
    addr_a      = addr_t'(case_field[c][0]);
    addr_b      = addr_t'(case_field[c][1]);
    addr_c      = addr_t'(case_field[c][2]);
    stride_a    = stride_t'(case_field[c][3]);
    stride_b    = stride_t'(case_field[c][4]);
    stride_c    = stride_t'(case_field[c][5]);
    mask_a_rows = mask_t'(case_field[c][6]);
    mask_inner  = mask_t'(case_field[c][7]);
    mask_b_cols = mask_t'(case_field[c][8]);
    start       = 1'b1;

    // The read addresses step through the window from the first cycle on
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #1;
      compare(name, $sformatf("A address %0d", k), 32'(word_addr(addr_a, stride_a, k)),
              32'(a_addr));
      compare(name, $sformatf("B address %0d", k), 32'(word_addr(addr_b, stride_b, k)),
              32'(b_addr));
    end

    beats      = 0;
    cycles     = 0;
    avail_prev = 1'b0;
    seen_done  = 1'b0;
    while (!seen_done && cycles < case_cycles) begin
      @(posedge clk);
      #1;
      cycles++;
      if (c_data_available) begin
        if (beats > 0) begin
          compare(name, "C beats on consecutive cycles", 32'd1, 32'(avail_prev));
        end
        if (beats < n) begin
          compare(name, $sformatf("C column %0d", beats), exp_col[beats], c_data);
          compare(name, $sformatf("C address %0d", beats),
                  32'(word_addr(addr_c, stride_c, beats)), 32'(c_addr));
        end
        beats++;
      end
      if (done) begin
        seen_done = 1'b1;
        compare(name, "C beats before done", 32'(n), 32'(beats));
        compare(name, "last C beat just before done", 32'd1, 32'(avail_prev));
        compare(name, "data available with done", 32'd0, 32'(c_data_available));
      end
      avail_prev = c_data_available;
    end

    if (!seen_done) begin
      $display("Case %s got no done pulse within %0d cycles", name, case_cycles);
      errors++;
    end else begin
      @(posedge clk);
      #1;
      compare(name, "done one cycle after its pulse", 32'd0, 32'(done));
      compare(name, "data available after done", 32'd0, 32'(c_data_available));
    end

    start = 1'b0;
    @(posedge clk);
    #1;
    compare(name, "done with start low", 32'd0, 32'(done));
    compare(name, "data available with start low", 32'd0, 32'(c_data_available));
    compare(name, "C data with start low", 32'd0, c_data);
  endtask

  //////////////////////////////////////////////////
  // Memory model with one cycle of read latency
  //////////////////////////////////////////////////
  initial begin
    a_data = '0;
    b_data = '0;
    forever begin
      @(posedge clk);
      #1;
      a_data = mem[a_rd_q];
      b_data = mem[b_rd_q];
      a_rd_q = a_addr;
      b_rd_q = b_addr;
    end
  end

  initial begin
    wait (cases_loaded);
    repeat ((n_cases + 2) * case_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles before all cases ended",
             (n_cases + 2) * case_cycles);
    errors++;
    finish_run();
  end

  initial begin
    start        = 1'b0;
    addr_a       = '0;
    addr_b       = '0;
    addr_c       = '0;
    stride_a     = '0;
    stride_b     = '0;
    stride_c     = '0;
    mask_a_rows  = '0;
    mask_inner   = '0;
    mask_b_cols  = '0;
    errors       = 0;
    checks       = 0;
    n_cases      = 0;
    cases_loaded = 1'b0;
    lfsr_state   = 32'haff9b539;
    for (int a = 0; a < mem_words; a++) begin
      mem[a] = background_word(addr_t'(a));
    end
    load_cases();
    cases_loaded = 1'b1;

    wait (!reset);
    @(posedge clk);
    #1;
    compare("reset", "done", 32'd0, 32'(done));
    compare("reset", "data available", 32'd0, 32'(c_data_available));
    compare("reset", "C data", 32'd0, c_data);
    compare("reset", "C address", 32'd0, 32'(c_addr));
    compare("reset", "A address", 32'd0, 32'(a_addr));
    compare("reset", "B address", 32'd0, 32'(b_addr));

    for (int c = 0; c < n_cases; c++) begin
      run_case(c);
    end
    finish_run();
  end

endmodule

// ==== sim/matmul_cases.txt ====
# name mode(0 fixed, 1 random A and B) a_base b_base c_base a_stride b_stride c_stride
# mask_a_rows mask_inner mask_b_cols, then A column words 0-3, B row words 0-3, C column words 0-3
plain_small 0 010 080 200 01 01 01 f f f
  01020001 01000102 01010300 01010201
  01020001 00010100 02000101 01010002
  04050703 02010402 04050305 04050802
saturate 0 100 140 300 04 04 01 f f f
  4001807f 4001807f 4001807f 4001807f
  00feff02 00feff02 00feff02 00feff02
  fc0800fc 00fcfc04 00f8fc00 00000000
masked 0 020 0a0 400 01 01 02 d b b
  01020001 01000102 01010300 01010201
  01020001 00010100 02000101 01010002
  03040003 01000002 00000000 02030002
random_full 1 300 380 000 10 10 10 f f f
  0 0 0 0 0 0 0 0 0 0 0 0
random_wrap 1 7f0 040 7fc 08 03 02 f f f
  0 0 0 0 0 0 0 0 0 0 0 0
random_masks 1 500 600 100 20 20 ff 7 e 5
  0 0 0 0 0 0 0 0 0 0 0 0
random_no_rows 1 050 060 0f0 01 01 01 0 f f
  0 0 0 0 0 0 0 0 0 0 0 0
random_no_inner 1 200 010 7ff ff 01 ff f 0 f
  0 0 0 0 0 0 0 0 0 0 0 0

// ==== sim.f ====
+incdir+design
design/matmul_pkg.sv
design/matmul_ctrl.sv
design/operand_feeder.sv
design/pe_mac.sv
design/systolic_array.sv
design/result_shifter.sv
design/matmul_top.sv
sim/tb_clock_gen.sv
sim/tb_matmul.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the matmul testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_matmul -f sim.f -o tb_matmul \
  && ./obj_dir/tb_matmul > sim.log 2>&1 \
  || echo "Build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "^Everything OK$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
